// ==== src/dotp_pkg.sv ====
// Dot-product accelerator package
// Widths, register map, AXI response codes and the opcode and FSM state types
`default_nettype none

package dotp_pkg;

   // Datapath geometry
   localparam int data_width = 8;
   localparam int lanes      = 4;
   localparam int word_width = lanes * data_width;
   localparam int depth      = 16;
   localparam int addr_width = 4;
   // Two guard bits cover the sum of four full-scale lane products
   localparam int prod_width = 2 * data_width + 2;
   localparam int acc_width  = 32;

   // AXI4-Lite geometry
   localparam int axi_addr_width = 8;
   localparam int axi_data_width = 32;

   // ------------------------------------------------------------------------
   // Register map (byte addresses)
   // ------------------------------------------------------------------------
   localparam logic [axi_addr_width-1:0] reg_ctrl    = 8'h00;
   localparam logic [axi_addr_width-1:0] reg_status  = 8'h04;
   localparam logic [axi_addr_width-1:0] reg_len     = 8'h08;
   localparam logic [axi_addr_width-1:0] reg_result  = 8'h0C;
   localparam logic [axi_addr_width-1:0] bank_a_base = 8'h40;
   localparam logic [axi_addr_width-1:0] bank_b_base = 8'h80;

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // The last code is reserved and is refused with SLVERR
   typedef enum logic [1:0] {
      OP_DOT     = 2'd0,
      OP_DOT_ACC = 2'd1,
      OP_CLEAR   = 2'd2,
      OP_RSVD    = 2'd3
   } dotp_op_e;

   typedef enum logic [1:0] {
      ST_IDLE, ST_CLEAR, ST_ISSUE, ST_DRAIN
   } ctrl_state_e;

endpackage

`default_nettype wire

// ==== src/operand_bank.sv ====
// Operand banks A and B
// Host writes through the register port, registered reads for the stream and readback
`timescale 1ns/1ps
`default_nettype none

module operand_bank (
   input  logic                           clk,
   input  logic                           wr_en,
   input  logic                           wr_sel,
   input  logic [dotp_pkg::addr_width-1:0] wr_addr,
   input  logic [dotp_pkg::word_width-1:0] wr_data,
   input  logic [dotp_pkg::addr_width-1:0] rd_addr,
   input  logic                           rb_sel,
   input  logic [dotp_pkg::addr_width-1:0] rb_addr,
   output logic [dotp_pkg::word_width-1:0] rd_a,
   output logic [dotp_pkg::word_width-1:0] rd_b,
   output logic [dotp_pkg::word_width-1:0] rb_data
);

   import dotp_pkg::*;

   logic [word_width-1:0] mem_a [depth];
   logic [word_width-1:0] mem_b [depth];

   // wr_sel low picks bank A, high picks bank B
   always_ff @(posedge clk) begin
      if (wr_en) begin
         if (wr_sel) begin
            mem_b[wr_addr] <= wr_data;
         end else begin
            mem_a[wr_addr] <= wr_data;
         end
      end
   end

   // Streaming port reads both banks at the same index
   always_ff @(posedge clk) begin
      rd_a <= mem_a[rd_addr];
      rd_b <= mem_b[rd_addr];
   end

   // Readback port for the host, same one-cycle latency as the stream
   always_ff @(posedge clk) begin
      if (rb_sel) begin
         rb_data <= mem_b[rb_addr];
      end else begin
         rb_data <= mem_a[rb_addr];
      end
   end

endmodule

`default_nettype wire

// ==== src/dot4_dsp.sv ====
// Four-lane signed dot product with skewed lanes and a systolic adder chain
// Result and valid/last sideband appear four enabled cycles after the input word
`timescale 1ns/1ps
`default_nettype none

module dot4_dsp (
   input  logic                                  clk,
   input  logic                                  arst_n,
   input  logic                                  ena,
   input  logic                                  in_valid,
   input  logic                                  in_last,
   input  logic        [dotp_pkg::word_width-1:0] a_word,
   input  logic        [dotp_pkg::word_width-1:0] b_word,
   output logic                                  out_valid,
   output logic                                  out_last,
   output logic signed [dotp_pkg::prod_width-1:0] res
);

   import dotp_pkg::*;

   // Lane operands once lined up with their stage of the chain
   logic signed [data_width-1:0]   a_al [lanes];
   logic signed [data_width-1:0]   b_al [lanes];
   logic signed [2*data_width-1:0] prod [lanes];
   // Running partial sum, one register per lane stage
   logic signed [prod_width-1:0]   psum [lanes];
   logic [lanes-1:0]               vld_sr;
   logic [lanes-1:0]               lst_sr;

   // ------------------------------------------------------------------------
   // Lane skew
   // ------------------------------------------------------------------------
   // Lane k is held k stages so it meets the partial sum at stage k
   for (genvar k = 0; k < lanes; k++) begin : g_lane
      if (k == 0) begin : g_direct
         assign a_al[k] = a_word[data_width-1:0];
         assign b_al[k] = b_word[data_width-1:0];
      end else begin : g_skew
         logic signed [data_width-1:0] a_sr [k];
         logic signed [data_width-1:0] b_sr [k];

         always_ff @(posedge clk) begin
            if (ena) begin
               a_sr[0] <= a_word[k*data_width +: data_width];
               b_sr[0] <= b_word[k*data_width +: data_width];
               for (int j = 1; j < k; j++) begin
                  a_sr[j] <= a_sr[j-1];
                  b_sr[j] <= b_sr[j-1];
               end
            end
         end

         assign a_al[k] = a_sr[k-1];
         assign b_al[k] = b_sr[k-1];
      end
      assign prod[k] = a_al[k] * b_al[k];
   end

   // ------------------------------------------------------------------------
   // Systolic chain
   // ------------------------------------------------------------------------
   // Stages 0 and 1 are the first dot2 pair, its stage 1 sum is the chain
   // into the second pair at stages 2 and 3, whose last register is the output
   always_ff @(posedge clk) begin
      if (ena) begin
         psum[0] <= prod[0];
         for (int k = 1; k < lanes; k++) begin
            psum[k] <= psum[k-1] + prod[k];
         end
      end
   end

   // Sideband travels with the partial sum
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_sr <= '0;
         lst_sr <= '0;
      end else if (ena) begin
         vld_sr <= {vld_sr[lanes-2:0], in_valid};
         lst_sr <= {lst_sr[lanes-2:0], in_last};
      end
   end

   assign res       = psum[lanes-1];
   assign out_valid = vld_sr[lanes-1];
   assign out_last  = lst_sr[lanes-1];

endmodule

`default_nettype wire

// ==== src/dot_accumulator.sv ====
// Result accumulator
// Sums sign-extended dot products and flags the end of a run
`timescale 1ns/1ps
`default_nettype none

module dot_accumulator (
   input  logic                                  clk,
   input  logic                                  arst_n,
   input  logic                                  clear,
   input  logic                                  valid,
   input  logic                                  last,
   input  logic signed [dotp_pkg::prod_width-1:0] res,
   output logic signed [dotp_pkg::acc_width-1:0]  result,
   output logic                                  done
);

   import dotp_pkg::*;

   logic signed [acc_width-1:0] res_ext;

   assign res_ext = {{(acc_width-prod_width){res[prod_width-1]}}, res};

   // Clear wins over a term arriving in the same cycle
   // The sum wraps at acc_width bits
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result <= '0;
         done   <= 1'b0;
      end else begin
         done <= valid && last && !clear;
         if (clear) begin
            result <= '0;
         end else if (valid) begin
            result <= result + res_ext;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/dotp_ctrl.sv ====
// Accelerator control
// AXI4-Lite slave, register file, bank access and the run sequencer
`timescale 1ns/1ps
`default_nettype none

module dotp_ctrl (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic [dotp_pkg::axi_addr_width-1:0] s_axi_awaddr,
   input  logic                                s_axi_awvalid,
   output logic                                s_axi_awready,
   input  logic [dotp_pkg::axi_data_width-1:0] s_axi_wdata,
   input  logic                                s_axi_wvalid,
   output logic                                s_axi_wready,
   output logic [1:0]                          s_axi_bresp,
   output logic                                s_axi_bvalid,
   input  logic                                s_axi_bready,
   input  logic [dotp_pkg::axi_addr_width-1:0] s_axi_araddr,
   input  logic                                s_axi_arvalid,
   output logic                                s_axi_arready,
   output logic [dotp_pkg::axi_data_width-1:0] s_axi_rdata,
   output logic [1:0]                          s_axi_rresp,
   output logic                                s_axi_rvalid,
   input  logic                                s_axi_rready,
   input  logic [dotp_pkg::word_width-1:0]     bank_rdata,
   input  logic [dotp_pkg::acc_width-1:0]      acc_result,
   input  logic                                acc_done,
   output logic                                wr_en,
   output logic                                wr_sel,
   output logic [dotp_pkg::addr_width-1:0]     wr_addr,
   output logic [dotp_pkg::word_width-1:0]     wr_data,
   output logic [dotp_pkg::addr_width-1:0]     rd_addr,
   output logic                                rb_sel,
   output logic [dotp_pkg::addr_width-1:0]     rb_addr,
   output logic                                ena,
   output logic                                in_valid,
   output logic                                in_last,
   output logic                                acc_clear
);

   import dotp_pkg::*;

   ctrl_state_e                state;
   dotp_op_e                   op_q;
   dotp_op_e                   cmd_op;
   logic [addr_width-1:0]      len_q;
   logic [addr_width-1:0]      issue_addr;
   logic                       busy;
   logic                       done_q;
   logic                       wr_hs;
   logic                       wr_err;
   logic                       wr_ctrl;
   logic                       start;
   logic                       ar_hs;
   logic                       rd_bank_q;
   logic [axi_data_width-1:0]  rdata_q;
   logic [axi_data_width-1:0]  reg_rdata;

   // Banks sit at 0x40 and 0x80, each 16 words
   function automatic logic is_bank(input logic [axi_addr_width-1:0] a);
      return (a[7:6] == bank_a_base[7:6]) || (a[7:6] == bank_b_base[7:6]);
   endfunction

   // Registers occupy the first 16 bytes
   function automatic logic is_reg(input logic [axi_addr_width-1:0] a);
      return a[7:4] == 4'h0;
   endfunction

   // ------------------------------------------------------------------------
   // Write channel
   // ------------------------------------------------------------------------
   // Address and data are taken together in a single-cycle ready pulse
   assign s_axi_wready = s_axi_awready;
   assign wr_hs   = s_axi_awready && s_axi_awvalid && s_axi_wvalid;
   assign cmd_op  = dotp_op_e'(s_axi_wdata[2:1]);
   assign wr_ctrl = s_axi_awaddr[7:2] == reg_ctrl[7:2];
   assign wr_err  = !(is_reg(s_axi_awaddr) || is_bank(s_axi_awaddr)) ||
                    (wr_ctrl && cmd_op == OP_RSVD);
   // Writes while busy are answered but have no effect
   assign start   = wr_hs && wr_ctrl && s_axi_wdata[0] && !busy && cmd_op != OP_RSVD;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s_axi_awready <= 1'b0;
         s_axi_bvalid  <= 1'b0;
         s_axi_bresp   <= resp_okay;
      end else begin
         s_axi_awready <= s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !s_axi_awready;
         if (wr_hs) begin
            s_axi_bvalid <= 1'b1;
            s_axi_bresp  <= wr_err ? resp_slverr : resp_okay;
         end else if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
         end
      end
   end

   assign wr_en   = wr_hs && is_bank(s_axi_awaddr) && !busy;
   assign wr_sel  = s_axi_awaddr[7:6] == bank_b_base[7:6];
   assign wr_addr = s_axi_awaddr[5:2];
   assign wr_data = s_axi_wdata;

   // ------------------------------------------------------------------------
   // Read channel
   // ------------------------------------------------------------------------
   assign s_axi_arready = !s_axi_rvalid;
   assign ar_hs   = s_axi_arvalid && s_axi_arready;
   assign rb_sel  = s_axi_araddr[7:6] == bank_b_base[7:6];
   assign rb_addr = s_axi_araddr[5:2];

   // CTRL and unmapped locations read as zero
   always_comb begin
      reg_rdata = '0;
      if (is_reg(s_axi_araddr)) begin
         case (s_axi_araddr[3:2])
            reg_status[3:2]: reg_rdata = {{(axi_data_width-2){1'b0}}, done_q, busy};
            reg_len[3:2]:    reg_rdata = {{(axi_data_width-addr_width){1'b0}}, len_q};
            reg_result[3:2]: reg_rdata = acc_result;
            default:         reg_rdata = '0;
         endcase
      end
   end

   // Bank data arrives in the first rvalid cycle and is captured there so it
   // stays stable while the host stalls the response
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s_axi_rvalid <= 1'b0;
         s_axi_rresp  <= resp_okay;
         rd_bank_q    <= 1'b0;
         rdata_q      <= '0;
      end else if (ar_hs) begin
         s_axi_rvalid <= 1'b1;
         s_axi_rresp  <= (is_reg(s_axi_araddr) || is_bank(s_axi_araddr)) ?
                         resp_okay : resp_slverr;
         rd_bank_q    <= is_bank(s_axi_araddr);
         rdata_q      <= reg_rdata;
      end else begin
         if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
         end
         if (rd_bank_q) begin
            rdata_q   <= bank_rdata;
            rd_bank_q <= 1'b0;
         end
      end
   end

   assign s_axi_rdata = rd_bank_q ? bank_rdata : rdata_q;

   // ------------------------------------------------------------------------
   // Run sequencer
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= ST_IDLE;
         op_q       <= OP_DOT;
         len_q      <= '0;
         issue_addr <= '0;
         done_q     <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (wr_hs && s_axi_awaddr[7:2] == reg_len[7:2]) begin
                  len_q <= s_axi_wdata[addr_width-1:0];
               end
               if (start) begin
                  op_q       <= cmd_op;
                  issue_addr <= '0;
                  done_q     <= 1'b0;
                  state      <= (cmd_op == OP_DOT_ACC) ? ST_ISSUE : ST_CLEAR;
               end
            end
            // OP_CLEAR ends after the clear cycle
            ST_CLEAR: begin
               if (op_q == OP_CLEAR) begin
                  done_q <= 1'b1;
                  state  <= ST_IDLE;
               end else begin
                  state <= ST_ISSUE;
               end
            end
            ST_ISSUE: begin
               issue_addr <= issue_addr + 1'b1;
               if (issue_addr == len_q) begin
                  state <= ST_DRAIN;
               end
            end
            ST_DRAIN: begin
               if (acc_done) begin
                  done_q <= 1'b1;
                  state  <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Flags lag the address by one cycle to meet the registered bank data
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         in_valid <= 1'b0;
         in_last  <= 1'b0;
      end else begin
         in_valid <= state == ST_ISSUE;
         in_last  <= state == ST_ISSUE && issue_addr == len_q;
      end
   end

   assign busy      = state != ST_IDLE;
   assign ena       = busy;
   assign rd_addr   = issue_addr;
   assign acc_clear = state == ST_CLEAR;

endmodule

`default_nettype wire

// ==== src/dotp_top.sv ====
// Dot-product accelerator top level
// Wires the control block to the operand banks, the dot4 pipeline and the accumulator
`timescale 1ns/1ps
`default_nettype none

module dotp_top (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic [dotp_pkg::axi_addr_width-1:0] s_axi_awaddr,
   input  logic                                s_axi_awvalid,
   output logic                                s_axi_awready,
   input  logic [dotp_pkg::axi_data_width-1:0] s_axi_wdata,
   input  logic                                s_axi_wvalid,
   output logic                                s_axi_wready,
   output logic [1:0]                          s_axi_bresp,
   output logic                                s_axi_bvalid,
   input  logic                                s_axi_bready,
   input  logic [dotp_pkg::axi_addr_width-1:0] s_axi_araddr,
   input  logic                                s_axi_arvalid,
   output logic                                s_axi_arready,
   output logic [dotp_pkg::axi_data_width-1:0] s_axi_rdata,
   output logic [1:0]                          s_axi_rresp,
   output logic                                s_axi_rvalid,
   input  logic                                s_axi_rready
);

   import dotp_pkg::*;

   // Bank write and read ports
   logic                   wr_en;
   logic                   wr_sel;
   logic [addr_width-1:0]  wr_addr;
   logic [word_width-1:0]  wr_data;
   logic [addr_width-1:0]  rd_addr;
   logic                   rb_sel;
   logic [addr_width-1:0]  rb_addr;
   logic [word_width-1:0]  rd_a;
   logic [word_width-1:0]  rd_b;
   logic [word_width-1:0]  rb_data;
   // Stream and result
   logic                   ena;
   logic                   in_valid;
   logic                   in_last;
   logic                   acc_clear;
   logic                   dot_valid;
   logic                   dot_last;
   logic signed [prod_width-1:0] dot_res;
   logic signed [acc_width-1:0]  acc_result;
   logic                   acc_done;

   dotp_ctrl i_dotp_ctrl (
      .clk, .arst_n,
      .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
      .s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
      .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
      .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
      .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
      .bank_rdata (rb_data),
      .acc_result, .acc_done,
      .wr_en, .wr_sel, .wr_addr, .wr_data,
      .rd_addr, .rb_sel, .rb_addr,
      .ena, .in_valid, .in_last, .acc_clear
   );

   operand_bank i_operand_bank (
      .clk, .wr_en, .wr_sel, .wr_addr, .wr_data,
      .rd_addr, .rb_sel, .rb_addr,
      .rd_a, .rd_b, .rb_data
   );

   dot4_dsp i_dot4_dsp (
      .clk, .arst_n, .ena, .in_valid, .in_last,
      .a_word    (rd_a),
      .b_word    (rd_b),
      .out_valid (dot_valid),
      .out_last  (dot_last),
      .res       (dot_res)
   );

   dot_accumulator i_dot_accumulator (
      .clk, .arst_n,
      .clear  (acc_clear),
      .valid  (dot_valid),
      .last   (dot_last),
      .res    (dot_res),
      .result (acc_result),
      .done   (acc_done)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_dotp.sv ====
// Testbench for the dot-product accelerator
// Drives random AXI4-Lite traffic and checks every run against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_dotp;

   import dotp_pkg::*;

   localparam int timeout_cycles = 200;

   logic                        clk;
   logic                        arst_n;
   logic [axi_addr_width-1:0]   s_axi_awaddr;
   logic                        s_axi_awvalid;
   logic                        s_axi_awready;
   logic [axi_data_width-1:0]   s_axi_wdata;
   logic                        s_axi_wvalid;
   logic                        s_axi_wready;
   logic [1:0]                  s_axi_bresp;
   logic                        s_axi_bvalid;
   logic                        s_axi_bready;
   logic [axi_addr_width-1:0]   s_axi_araddr;
   logic                        s_axi_arvalid;
   logic                        s_axi_arready;
   logic [axi_data_width-1:0]   s_axi_rdata;
   logic [1:0]                  s_axi_rresp;
   logic                        s_axi_rvalid;
   logic                        s_axi_rready;

   // Reference copy of both banks and the expected result register
   logic [word_width-1:0]       model_a [depth];
   logic [word_width-1:0]       model_b [depth];
   logic signed [acc_width-1:0] model_result;
   // When set the host stalls bready and rready for a few random cycles
   logic                        bp_en;

   dotp_top i_dotp_top (
      .clk, .arst_n,
      .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
      .s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
      .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
      .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
      .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------------------
   task automatic fail_timeout(input string what);
      $display("TIMEOUT at %0t: no %s within %0d cycles", $time, what, timeout_cycles);
      $display("Simulation failed");
      $fatal(1, "Run stopped on a timeout");
   endtask

   task automatic check_word(input string name, input logic [word_width-1:0] got,
                             input logic [word_width-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "Word compare error");
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] got,
                             input logic [1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "Response compare error");
      end
   endtask

   task automatic check_result(input string name, input logic signed [acc_width-1:0] got,
                               input logic signed [acc_width-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "Result compare error");
      end
   endtask

   // ------------------------------------------------------------------------
   // AXI4-Lite host
   // ------------------------------------------------------------------------
   // All host tasks start and end on a falling edge
   task automatic resp_stall();
      int n;
      n = bp_en ? int'($urandom_range(0, 3)) : 0;
      repeat (n) @(negedge clk);
   endtask

   task automatic axi_write(input logic [axi_addr_width-1:0] addr,
                            input logic [axi_data_width-1:0] data,
                            output logic [1:0] resp);
      int cnt;
      s_axi_awaddr  = addr;
      s_axi_wdata   = data;
      s_axi_awvalid = 1'b1;
      s_axi_wvalid  = 1'b1;
      cnt = 0;
      // High awready and wready seen here mean the handshake happens at the next rising edge
      do begin
         @(negedge clk);
         cnt++;
         if (cnt > timeout_cycles) fail_timeout("write address and data handshake");
      end while (!(s_axi_awready && s_axi_wready));
      @(negedge clk);
      s_axi_awvalid = 1'b0;
      s_axi_wvalid  = 1'b0;
      resp_stall();
      s_axi_bready = 1'b1;
      cnt = 0;
      while (!s_axi_bvalid) begin
         @(negedge clk);
         cnt++;
         if (cnt > timeout_cycles) fail_timeout("write response");
      end
      resp = s_axi_bresp;
      @(negedge clk);
      s_axi_bready = 1'b0;
   endtask

   task automatic axi_read(input logic [axi_addr_width-1:0] addr,
                           output logic [axi_data_width-1:0] data,
                           output logic [1:0] resp);
      int cnt;
      s_axi_araddr  = addr;
      s_axi_arvalid = 1'b1;
      cnt = 0;
      while (!s_axi_arready) begin
         @(negedge clk);
         cnt++;
         if (cnt > timeout_cycles) fail_timeout("read address handshake");
      end
      @(negedge clk);
      s_axi_arvalid = 1'b0;
      resp_stall();
      s_axi_rready = 1'b1;
      cnt = 0;
      while (!s_axi_rvalid) begin
         @(negedge clk);
         cnt++;
         if (cnt > timeout_cycles) fail_timeout("read data");
      end
      // Data and response hold steady until the rising edge that completes the beat
      data = s_axi_rdata;
      resp = s_axi_rresp;
      @(negedge clk);
      s_axi_rready = 1'b0;
   endtask

   // ------------------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------------------
   // Signed lane products summed over words 0..len, wrapping at 32 bits
   function automatic logic signed [acc_width-1:0] dot_sum(input logic [addr_width-1:0] len);
      logic signed [data_width-1:0] la;
      logic signed [data_width-1:0] lb;
      logic signed [acc_width-1:0]  sum;
      sum = '0;
      for (int i = 0; i <= int'(len); i++) begin
         for (int k = 0; k < lanes; k++) begin
            la = model_a[i][k*data_width +: data_width];
            lb = model_b[i][k*data_width +: data_width];
            sum = sum + la * lb;
         end
      end
      return sum;
   endfunction

   // Every lane is full-scale negative or full-scale positive
   function automatic logic [word_width-1:0] extreme_word();
      logic [word_width-1:0] w;
      for (int k = 0; k < lanes; k++) begin
         w[k*data_width +: data_width] = ($urandom_range(0, 1) != 0) ? 8'h80 : 8'h7F;
      end
      return w;
   endfunction

   function automatic logic [axi_addr_width-1:0] bank_addr(input logic sel,
                                                           input logic [addr_width-1:0] idx);
      return (sel ? bank_b_base : bank_a_base) + {2'b00, idx, 2'b00};
   endfunction

   task automatic write_bank(input logic sel, input logic [addr_width-1:0] idx,
                             input logic [word_width-1:0] w);
      logic [1:0] resp;
      axi_write(bank_addr(sel, idx), w, resp);
      check_resp("s_axi_bresp", resp, resp_okay);
   endtask

   task automatic fill_banks(input logic extreme);
      logic [word_width-1:0] wa;
      logic [word_width-1:0] wb;
      for (int i = 0; i < depth; i++) begin
         wa = extreme ? extreme_word() : $urandom();
         wb = extreme ? extreme_word() : $urandom();
         write_bank(1'b0, 4'(i), wa);
         write_bank(1'b1, 4'(i), wb);
         model_a[i] = wa;
         model_b[i] = wb;
      end
   endtask

   task automatic check_bank(input logic sel, input logic [addr_width-1:0] idx);
      logic [word_width-1:0] data;
      logic [1:0]            resp;
      string                 name;
      name = sel ? "bank_b word" : "bank_a word";
      axi_read(bank_addr(sel, idx), data, resp);
      check_resp("s_axi_rresp", resp, resp_okay);
      check_word(name, data, sel ? model_b[idx] : model_a[idx]);
   endtask

   // ------------------------------------------------------------------------
   // Run control
   // ------------------------------------------------------------------------
   task automatic start_run(input dotp_op_e op, input logic [addr_width-1:0] len);
      logic [1:0] resp;
      axi_write(reg_len, {{(axi_data_width-addr_width){1'b0}}, len}, resp);
      check_resp("s_axi_bresp", resp, resp_okay);
      axi_write(reg_ctrl, {29'h0, op, 1'b1}, resp);
      check_resp("s_axi_bresp", resp, resp_okay);
   endtask

   // Polls STATUS until busy is low and the sticky done bit is set
   task automatic wait_done();
      logic [axi_data_width-1:0] data;
      logic [1:0]                resp;
      int                        polls;
      polls = 0;
      do begin
         axi_read(reg_status, data, resp);
         check_resp("s_axi_rresp", resp, resp_okay);
         polls++;
         if (polls > timeout_cycles) fail_timeout("end of run in STATUS");
      end while (data[1:0] != 2'b10);
   endtask

   task automatic check_run_result();
      logic [axi_data_width-1:0] data;
      logic [1:0]                resp;
      axi_read(reg_result, data, resp);
      check_resp("s_axi_rresp", resp, resp_okay);
      check_result("RESULT", data, model_result);
   endtask

   task automatic run_op(input dotp_op_e op, input logic [addr_width-1:0] len);
      case (op)
         OP_DOT:     model_result = dot_sum(len);
         OP_DOT_ACC: model_result = model_result + dot_sum(len);
         default:    model_result = '0;
      endcase
      start_run(op, len);
      wait_done();
      check_run_result();
   endtask

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------
   initial begin
      logic [axi_data_width-1:0] data;
      logic [1:0]                resp;
      logic [word_width-1:0]     old_word;
      void'($urandom(32'h14de_95b3));
      arst_n        = 1'b0;
      s_axi_awaddr  = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      s_axi_araddr  = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      bp_en         = 1'b0;
      model_result  = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      // Idle state straight out of reset
      axi_read(reg_status, data, resp);
      check_resp("s_axi_rresp", resp, resp_okay);
      check_word("STATUS", data, '0);
      check_run_result();

      // Bank write and readback under response back-pressure
      bp_en = 1'b1;
      fill_banks(1'b0);
      for (int i = 0; i < depth; i++) begin
         check_bank(1'b0, 4'(i));
         check_bank(1'b1, 4'(i));
      end

      // Plain run, accumulate on top of it, then clear
      run_op(OP_DOT, 4'($urandom_range(0, 15)));
      run_op(OP_DOT_ACC, 4'($urandom_range(0, 15)));
      run_op(OP_CLEAR, 4'd0);
      run_op(OP_DOT, 4'($urandom_range(0, 15)));

      // Refused accesses leave the result alone
      axi_write(reg_ctrl, {29'h0, OP_RSVD, 1'b1}, resp);
      check_resp("s_axi_bresp", resp, resp_slverr);
      axi_write(8'h20, $urandom(), resp);
      check_resp("s_axi_bresp", resp, resp_slverr);
      axi_read(8'hC4, data, resp);
      check_resp("s_axi_rresp", resp, resp_slverr);
      check_word("unmapped read data", data, '0);
      check_run_result();

      // A bank write landing inside a full-length run has no effect
      model_result = dot_sum(4'd15);
      old_word = model_a[3];
      start_run(OP_DOT, 4'd15);
      write_bank(1'b0, 4'd3, ~old_word);
      wait_done();
      check_run_result();
      check_bank(1'b0, 4'd3);

      // Full-scale lanes with random opcode and length
      for (int r = 0; r < 20; r++) begin
         fill_banks(1'b1);
         run_op(dotp_op_e'($urandom_range(0, 1)), 4'($urandom_range(0, 15)));
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
src/dotp_pkg.sv
src/operand_bank.sv
src/dot4_dsp.sv
src/dot_accumulator.sv
src/dotp_ctrl.sv
src/dotp_top.sv
testbench/tb_dotp.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_dotp
RTL_TOP    = dotp_top
FILELIST   = compile.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing -Wall -Wno-fatal
SIM_FLAGS  = --binary --timing -Wno-fatal --Mdir $(OBJ_DIR)
PASS_MSG   = Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
